// File: Makefile
VERILATOR ?= verilator
TOP       := fb_display_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR)
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the simulator exits non-zero when the testbench stops with $fatal
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
verilog/fb_pkg.sv
verilog/frame_store.sv
verilog/apb_pixel_port.sv
verilog/scan_timing.sv
verilog/fb_display_top.sv
dv/fb_display_tb.sv

// File: dv/fb_display_tb.sv
`timescale 1ns/10ps

module fb_display_tb
   import fb_pkg::*;
();

   localparam int DEPTH          = 16384;
   localparam int H_ACTIVE       = 16;
   localparam int V_ACTIVE       = 8;
   localparam int PORCH          = 2;
   localparam int SYNC           = 3;
   localparam int BACK           = 2;
   localparam int LINE_LEN       = H_ACTIVE + PORCH + SYNC + BACK;
   localparam int FRAME_LEN      = LINE_LEN * (V_ACTIVE + PORCH + SYNC + BACK);
   localparam int EDGE_TIMEOUT   = 2 * FRAME_LEN;
   localparam int PREADY_TIMEOUT = 16;
   localparam int REGION         = H_ACTIVE * V_ACTIVE;

   logic      clk = 1'b0;
   logic      arst_n;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      pready;
   logic      pslverr;
   logic      hsync;
   logic      vsync;
   logic      de;
   logic      pixel;

   logic      model_pix [0:DEPTH-1];       // reference copy of the store
   pix_addr_t model_ptr;
   logic      model_en;
   int        seed = 32'h85fab745;
   int        vsync_rises;                 // rising vsync edges seen since reset
   logic      vsync_q;
   int        read_rises;                  // vsync_rises at the last read completion

   fb_display_top #(
      .DEPTH    (DEPTH),
      .H_ACTIVE (H_ACTIVE),
      .H_FRONT  (PORCH),
      .H_SYNC   (SYNC),
      .H_BACK   (BACK),
      .V_ACTIVE (V_ACTIVE),
      .V_FRONT  (PORCH),
      .V_SYNC   (SYNC),
      .V_BACK   (BACK)
   ) dut_i (
      .clk     (clk),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .hsync   (hsync),
      .vsync   (vsync),
      .de      (de),
      .pixel   (pixel)
   );

   always #4 clk = ~clk;

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vsync_q     <= 1'b0;
         vsync_rises <= 0;
      end else begin
         vsync_q <= vsync;
         if (vsync && !vsync_q) begin
            vsync_rises <= vsync_rises + 1;
         end
      end
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at %0t ns", $time);
   endtask

   task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail %0t ns %s got %08h expected %08h", $time, name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail %0t ns %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   function automatic logic is_mapped(input apb_addr_t off);
      return off == REG_ADDR || off == REG_DATA || off == REG_CTRL || off == REG_STATUS;
   endfunction

   function automatic void step_ptr();
      model_ptr = pix_addr_t'((int'(model_ptr) + 1) % DEPTH);   // wraps at the store depth
   endfunction

   task automatic wait_pready(output int cycles);
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > PREADY_TIMEOUT) begin
            abort_run("timeout: pready never came during an APB transfer");
         end
      end while (!pready);
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
      int cycles;
      @(posedge clk);
      psel    <= 1'b1;                     // setup cycle
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      wait_pready(cycles);
      err = pslverr;
      psel    <= 1'b0;
      penable <= 1'b0;
      check_word("pready access cycles", cycles, 1);
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
      int cycles;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      wait_pready(cycles);
      data       = prdata;
      err        = pslverr;
      read_rises = vsync_rises;            // frames seen up to this transfer
      psel    <= 1'b0;
      penable <= 1'b0;
      // a data read waits one cycle for the store
      check_word("pready access cycles", cycles, (addr == REG_DATA) ? 2 : 1);
   endtask

   // one whole frame after the next vsync, counted from de
   task automatic frame_check();
      int   n;
      int   row;
      int   col;
      int   hs_rises;
      logic vs_q;
      logic de_q;
      logic hs_q;
      logic exp;
      n    = 0;
      vs_q = 1'b0;
      do begin
         @(posedge clk);
         n++;
         if (n > EDGE_TIMEOUT) begin
            abort_run("timeout: vsync never fell before a frame check");
         end
         exp  = vs_q && !vsync;            // falling edge
         vs_q = vsync;
      end while (!exp);
      n        = 0;
      row      = 0;
      col      = 0;
      hs_rises = 0;
      de_q     = 1'b0;
      hs_q     = 1'b0;
      do begin
         @(posedge clk);
         n++;
         if (n > EDGE_TIMEOUT) begin
            abort_run("timeout: vsync never rose after the checked frame");
         end
         check_bit("de&vsync", de && vsync, 1'b0);
         if (de) begin
            exp = model_en ? model_pix[row * H_ACTIVE + col] : 1'b0;
            check_bit($sformatf("pixel[%0d][%0d]", row, col), pixel, exp);
            col++;
         end else if (de_q) begin
            check_word("de cycles per line", col, H_ACTIVE);
            row++;
            col = 0;
         end
         if (hsync && !hs_q) begin
            hs_rises++;
         end
         de_q = de;
         hs_q = hsync;
      end while (!vsync);
      check_word("lines with de", row, V_ACTIVE);
      check_word("hsync pulses", hs_rises, BACK + V_ACTIVE + PORCH);   // lines between vsyncs
   endtask

   task automatic run_command(input logic [7:0] cmd, input apb_addr_t off,
                              input apb_data_t data);
      logic                   err;
      apb_data_t              got;
      apb_data_t              exp;
      logic [FRAME_CNT_W-1:0] cnt;
      case (cmd)
         "W": begin
            apb_write(off, data, err);
            check_bit("pslverr", err, !is_mapped(off));
            if (off == REG_ADDR) begin
               model_ptr = pix_addr_t'(int'(data[PIX_ADDR_W-1:0]) % DEPTH);
            end else if (off == REG_DATA) begin
               model_pix[model_ptr] = data[0];
               step_ptr();
            end else if (off == REG_CTRL) begin
               model_en = data[CTRL_EN_BIT];
            end
         end
         "R": begin
            apb_read(off, got, err);
            check_bit("pslverr", err, !is_mapped(off));
            exp = data;
            if (off == REG_STATUS) begin
               // one count per vsync rise since reset, modulo 16 bits
               cnt = FRAME_CNT_W'(read_rises);
               exp = apb_data_t'(cnt);
            end else if (off == REG_DATA) begin
               step_ptr();
            end
            check_word($sformatf("prdata@%03h", off), got, exp);
         end
         "F": frame_check();
         default: abort_run($sformatf("unknown command '%c' in the vectors file", cmd));
      endcase
   endtask

   task automatic random_fill();
      logic b;
      run_command("W", REG_ADDR, '0);
      for (int i = 0; i < REGION; i++) begin
         b = 1'($random(seed));
         run_command("W", REG_DATA, apb_data_t'(b));
      end
      run_command("R", REG_ADDR, apb_data_t'(REGION));
   endtask

   initial begin
      int         fd;
      int         fields;
      string      line;
      logic [7:0] cmd;
      apb_addr_t  off;
      apb_data_t  data;
      arst_n      = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      model_ptr   = '0;
      model_en    = 1'b0;
      read_rises  = 0;
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
      fd = $fopen("dv/fb_vectors.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open dv/fb_vectors.txt");
      end
      while ($fgets(line, fd) > 0) begin
         if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
            continue;
         end
         fields = $sscanf(line, "%c %h %h", cmd, off, data);
         if (cmd != "F" && fields != 3) begin
            abort_run($sformatf("malformed line in the vectors file: %s", line));
         end
         run_command(cmd, off, data);
      end
      $fclose(fd);
      run_command("W", REG_CTRL, 32'h1);   // picture on for the random frames
      random_fill();
      frame_check();
      random_fill();
      frame_check();
      run_command("R", REG_STATUS, '0);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// File: dv/fb_vectors.txt
# W offset data: APB write | R offset expected: APB read | F: check one frame
# hex values; the STATUS expect column is unused, frame counts come from vsync edges
R 008 00000000
R 000 00000000
R 00c 00000000
R 010 00000000
W 000 00000020
W 004 00000001
W 004 00000000
W 004 00000001
W 004 00000001
W 004 00000000
R 000 00000025
W 000 00000020
R 004 00000001
R 004 00000000
R 004 00000001
R 004 00000001
R 004 00000000
R 000 00000025
W 000 00003fff
W 004 00000001
R 000 00000000
W 000 00003fff
R 004 00000001
R 000 00000000
W 000 00004005
R 000 00000005
F
F
R 00c 00000000
R 008 00000000

// File: verilog/apb_pixel_port.sv
`timescale 1ns/10ps

module apb_pixel_port
   import fb_pkg::*;
#(
   parameter int DEPTH = 2**PIX_ADDR_W
) (
   input  logic      clk,
   input  logic      arst_n,
   // APB slave
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_addr_t paddr,
   input  apb_data_t pwdata,
   output apb_data_t prdata,
   output logic      pready,
   output logic      pslverr,
   // host side of the store
   output logic      host_re,
   output logic      host_we,
   output pix_addr_t host_addr,
   output logic      host_wbit,
   input  logic      host_rbit,
   // control and status
   output logic      display_en,
   input  logic      frame_done
);

   pix_addr_t              ptr;
   logic [FRAME_CNT_W-1:0] frame_cnt;
   logic                   rd_wait;              // data read waiting on store
   logic                   access;
   logic                   is_data;
   logic                   reg_hit;
   logic                   ptr_step;

   assign access  = psel && penable;
   assign is_data = (paddr == REG_DATA);
   assign reg_hit = paddr inside {REG_ADDR, REG_DATA, REG_CTRL, REG_STATUS};

   // data reads need one wait state for the synchronous store
   assign pready  = access && (pwrite || !is_data || rd_wait);
   assign pslverr = pready && !reg_hit;

   assign host_addr = ptr;
   assign host_wbit = pwdata[0];
   assign host_we   = access && pwrite && is_data;
   assign host_re   = access && !pwrite && is_data && !rd_wait;
   assign ptr_step  = host_we || (rd_wait && pready);    // data access completes

   always_comb begin
      prdata = '0;
      case (paddr)
         REG_ADDR:   prdata[PIX_ADDR_W-1:0]  = ptr;
         REG_DATA:   prdata[0]               = host_rbit;
         REG_CTRL:   prdata[CTRL_EN_BIT]     = display_en;
         REG_STATUS: prdata[FRAME_CNT_W-1:0] = frame_cnt;
         default:    prdata                  = '0;       // unmapped
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ptr        <= '0;
         display_en <= 1'b0;
         rd_wait    <= 1'b0;
      end else begin
         rd_wait <= host_re;
         if (access && pwrite && paddr == REG_ADDR) begin
            ptr <= pix_addr_t'(apb_data_t'(pwdata[PIX_ADDR_W-1:0]) % DEPTH);
         end else if (ptr_step) begin
            ptr <= (ptr == pix_addr_t'(DEPTH-1)) ? '0 : ptr + 1'b1;
         end
         if (access && pwrite && paddr == REG_CTRL) begin
            display_en <= pwdata[CTRL_EN_BIT];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         frame_cnt <= '0;
      end else if (frame_done) begin
         frame_cnt <= frame_cnt + 1'b1;  // wraps at 16 bits
      end
   end

   a_penable_psel: assert property (@(posedge clk) disable iff (!arst_n)
      penable |-> psel)
      else $error("penable high without psel");

   // the read completes from the address held over the wait state
   a_wait_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (access && !pready) |=> (access && $stable(paddr) && $stable(pwrite)))
      else $error("APB transfer changed during a wait state");

endmodule

// File: verilog/fb_display_top.sv
`timescale 1ns/10ps

module fb_display_top
   import fb_pkg::*;
#(
   parameter int DEPTH    = 16384,
   parameter int H_ACTIVE = 128,
   parameter int H_FRONT  = 8,
   parameter int H_SYNC   = 12,
   parameter int H_BACK   = 8,
   parameter int V_ACTIVE = 128,
   parameter int V_FRONT  = 2,
   parameter int V_SYNC   = 3,
   parameter int V_BACK   = 4
) (
   input  logic      clk,
   input  logic      arst_n,
   // APB
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_addr_t paddr,
   input  apb_data_t pwdata,
   output apb_data_t prdata,
   output logic      pready,
   output logic      pslverr,
   // video
   output logic      hsync,
   output logic      vsync,
   output logic      de,
   output logic      pixel
);

   logic      host_re;
   logic      host_we;
   pix_addr_t host_addr;
   logic      host_wbit;
   logic      host_rbit;
   logic      scan_re;
   pix_addr_t scan_addr;
   logic      scan_rbit;
   logic      display_en;
   logic      frame_done;

   frame_store #(
      .DEPTH (DEPTH)
   ) store_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .scan_re   (scan_re),
      .scan_addr (scan_addr),
      .scan_rbit (scan_rbit),
      .host_re   (host_re),
      .host_we   (host_we),
      .host_addr (host_addr),
      .host_wbit (host_wbit),
      .host_rbit (host_rbit)
   );

   apb_pixel_port #(
      .DEPTH (DEPTH)
   ) apb_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .host_re    (host_re),
      .host_we    (host_we),
      .host_addr  (host_addr),
      .host_wbit  (host_wbit),
      .host_rbit  (host_rbit),
      .display_en (display_en),
      .frame_done (frame_done)
   );

   scan_timing #(
      .H_ACTIVE (H_ACTIVE),
      .H_FRONT  (H_FRONT),
      .H_SYNC   (H_SYNC),
      .H_BACK   (H_BACK),
      .V_ACTIVE (V_ACTIVE),
      .V_FRONT  (V_FRONT),
      .V_SYNC   (V_SYNC),
      .V_BACK   (V_BACK)
   ) scan_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .display_en (display_en),
      .scan_re    (scan_re),
      .scan_addr  (scan_addr),
      .scan_rbit  (scan_rbit),
      .frame_done (frame_done),
      .hsync      (hsync),
      .vsync      (vsync),
      .de         (de),
      .pixel      (pixel)
   );

endmodule

// File: verilog/fb_pkg.sv
package fb_pkg;

   // pixel store geometry
   localparam int PIX_ADDR_W = 14;               // 16384 one-bit pixels
   typedef logic [PIX_ADDR_W-1:0] pix_addr_t;

   // APB bus shape
   localparam int APB_ADDR_W = 12;
   localparam int APB_DATA_W = 32;
   typedef logic [APB_ADDR_W-1:0] apb_addr_t;    // byte address
   typedef logic [APB_DATA_W-1:0] apb_data_t;

   // register map
   localparam apb_addr_t REG_ADDR   = 12'h000;   // pixel pointer, rw
   localparam apb_addr_t REG_DATA   = 12'h004;   // pixel at pointer, auto increment
   localparam apb_addr_t REG_CTRL   = 12'h008;   // display enable
   localparam apb_addr_t REG_STATUS = 12'h00c;   // frame counter, ro

   // register fields
   localparam int CTRL_EN_BIT = 0;
   localparam int FRAME_CNT_W = 16;

endpackage

// File: verilog/frame_store.sv
`timescale 1ns/10ps

// single-bit pixel memory
// scan port is read only, host port reads or writes, both with registered read data
module frame_store
   import fb_pkg::*;
#(
   parameter int DEPTH = 2**PIX_ADDR_W
) (
   input  logic      clk,
   input  logic      arst_n,
   // scan read port
   input  logic      scan_re,
   input  pix_addr_t scan_addr,
   output logic      scan_rbit,
   // host port
   input  logic      host_re,
   input  logic      host_we,
   input  pix_addr_t host_addr,
   input  logic      host_wbit,
   output logic      host_rbit
);

   logic mem [0:DEPTH-1];                        // cleared by the host after power up

   always_ff @(posedge clk) begin
      if (host_we) begin
         mem[host_addr] <= host_wbit;
      end
   end

   // same-cycle write to the scanned address gives the old bit
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         scan_rbit <= 1'b0;
      end else if (scan_re) begin
         scan_rbit <= mem[scan_addr];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         host_rbit <= 1'b0;
      end else if (host_re) begin
         host_rbit <= mem[host_addr];
      end
   end

   a_scan_addr_range: assert property (@(posedge clk) disable iff (!arst_n)
      scan_re |-> (scan_addr < DEPTH))
      else $error("scan address %0d beyond store depth", scan_addr);

   a_host_addr_range: assert property (@(posedge clk) disable iff (!arst_n)
      (host_re || host_we) |-> (host_addr < DEPTH))
      else $error("host address %0d beyond store depth", host_addr);

   a_host_rw_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(host_re && host_we))
      else $error("host read and write in the same cycle");

endmodule

// File: verilog/scan_timing.sv
`timescale 1ns/10ps

// raster counters and video pipeline
// stage 0 counter position, stage 1 store data, stage 2 registered outputs
module scan_timing
   import fb_pkg::*;
#(
   parameter int H_ACTIVE = 128,
   parameter int H_FRONT  = 8,
   parameter int H_SYNC   = 12,
   parameter int H_BACK   = 8,
   parameter int V_ACTIVE = 128,
   parameter int V_FRONT  = 2,
   parameter int V_SYNC   = 3,
   parameter int V_BACK   = 4
) (
   input  logic      clk,
   input  logic      arst_n,
   input  logic      display_en,
   // scan read port of the store
   output logic      scan_re,
   output pix_addr_t scan_addr,
   input  logic      scan_rbit,
   output logic      frame_done,
   // video out
   output logic      hsync,
   output logic      vsync,
   output logic      de,
   output logic      pixel
);

   localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
   localparam int HS_START  = H_ACTIVE + H_FRONT;
   localparam int VS_START  = V_ACTIVE + V_FRONT;
   localparam int HCW       = $clog2(H_TOTAL);
   localparam int VCW       = $clog2(V_TOTAL);

   logic [HCW-1:0] h_cnt;
   logic [VCW-1:0] v_cnt;
   logic           h_last;
   logic           v_last;
   pix_addr_t      pix_addr;                     // row * H_ACTIVE + column
   logic           de0, hs0, vs0;                // stage 0 flags
   logic           de1, hs1, vs1, en1;           // stage 1 flags

   if (H_ACTIVE * V_ACTIVE > 2**PIX_ADDR_W) begin : g_area_chk
      $error("active area %0d x %0d exceeds the pixel store", H_ACTIVE, V_ACTIVE);
   end

   assign h_last = (h_cnt == HCW'(H_TOTAL-1));
   assign v_last = (v_cnt == VCW'(V_TOTAL-1));
   assign de0    = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
   assign hs0    = (h_cnt >= HS_START) && (h_cnt < HS_START + H_SYNC);
   assign vs0    = (v_cnt >= VS_START) && (v_cnt < VS_START + V_SYNC);  // whole lines

   assign scan_re   = de0;
   assign scan_addr = pix_addr;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         h_cnt    <= '0;
         v_cnt    <= '0;
         pix_addr <= '0;
      end else begin
         if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
         if (h_last && v_last) begin
            pix_addr <= '0;                      // frame start
         end else if (de0) begin
            pix_addr <= pix_addr + 1'b1;
         end
      end
   end

   // flags wait one stage for the store read
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         de1 <= 1'b0;
         hs1 <= 1'b0;
         vs1 <= 1'b0;
         en1 <= 1'b0;
      end else begin
         de1 <= de0;
         hs1 <= hs0;
         vs1 <= vs0;
         en1 <= display_en;                      // sampled with the counter position
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         de         <= 1'b0;
         hsync      <= 1'b0;
         vsync      <= 1'b0;
         pixel      <= 1'b0;
         frame_done <= 1'b0;
      end else begin
         de         <= de1;
         hsync      <= hs1;
         vsync      <= vs1;
         pixel      <= de1 && en1 && scan_rbit;
         frame_done <= vs1 && !vsync;            // first vsync cycle
      end
   end

   // running address tracks the raster position
   a_scan_addr_pos: assert property (@(posedge clk) disable iff (!arst_n)
      scan_re |-> (int'(scan_addr) == int'(v_cnt) * H_ACTIVE + int'(h_cnt)))
      else $error("scan address %0d off the raster position", scan_addr);

endmodule
